// ==== common/cache_pkg.sv ====
package cache_pkg;

    localparam int offset_width   = 2;  // four words per line
    localparam int line_words     = 4;
    localparam int i_index_width  = 2;
    localparam int d_index_width  = 2;
    localparam int l2_index_width = 3;

    typedef logic [31:0]              addr_t;
    typedef logic [31:0]              word_t;
    typedef logic [32*line_words-1:0] line_t;  // word 0 in the low bits
    typedef logic [3:0]               strb_t;

    typedef struct packed {
        addr_t addr;
        logic  req;
    } fetch_req_t;

    typedef struct packed {
        addr_t addr;
        word_t wdata;
        strb_t wstrb;
        logic  wr;
        logic  req;
    } data_req_t;

    typedef struct packed {
        addr_t addr;
        line_t data;   // written word sits in its own slot
        strb_t wstrb;
        logic  req;
    } mem_wr_t;

    typedef enum logic [1:0] {i_lookup, i_fill_addr, i_fill_data} icache_state_t;

    typedef enum logic [1:0] {d_lookup, d_fill_addr, d_fill_data, d_write_through} dcache_state_t;

    typedef enum logic [2:0] {
        l2_idle, l2_lookup, l2_mem_read_addr, l2_mem_read_data, l2_mem_write, l2_respond
    } l2_state_t;

endpackage

// ==== icache/icache.sv ====
`timescale 1ns/1ps

module icache import cache_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  addr_t      fetch_addr,
    input  logic       fetch_valid,
    output logic       fetch_ready,
    output word_t      fetch_inst,
    output fetch_req_t l2_req,
    input  logic       l2_addr_ok,
    input  logic       l2_data_ok,
    input  line_t      l2_line
);

    logic [31:2+offset_width+i_index_width] tag_mem [1<<i_index_width];
    line_t                                  line_mem [1<<i_index_width];
    logic [(1<<i_index_width)-1:0]          valid_bits;
    icache_state_t                          state;

    logic [i_index_width-1:0] index;
    logic [offset_width-1:0]  word_sel;
    logic                     hit;

    assign index    = fetch_addr[2+offset_width +: i_index_width];
    assign word_sel = fetch_addr[2 +: offset_width];
    assign hit      = valid_bits[index]
                   && tag_mem[index] == fetch_addr[31:2+offset_width+i_index_width];

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= i_lookup;
            valid_bits  <= '0;
            fetch_ready <= 1'b0;
            l2_req.req  <= 1'b0;
        end else begin
            fetch_ready <= 1'b0;  // single-cycle pulse
            case (state)
                i_lookup: begin
                    // skip the cycle where ready is still up
                    if (fetch_valid && !fetch_ready) begin
                        if (hit) begin
                            fetch_ready <= 1'b1;
                            fetch_inst  <= line_mem[index][word_sel*32 +: 32];
                        end else begin
                            l2_req.addr <= {fetch_addr[31:2+offset_width], {(2+offset_width){1'b0}}};
                            l2_req.req  <= 1'b1;
                            state       <= i_fill_addr;
                        end
                    end
                end
                i_fill_addr: if (l2_addr_ok) state <= i_fill_data;
                i_fill_data: begin
                    if (l2_data_ok) begin
                        line_mem[index]   <= l2_line;
                        tag_mem[index]    <= fetch_addr[31:2+offset_width+i_index_width];
                        valid_bits[index] <= 1'b1;
                        l2_req.req        <= 1'b0;
                        state             <= i_lookup;  // hits on the way back
                    end
                end
                default: state <= i_lookup;
            endcase
        end
    end

endmodule

// ==== dcache/dcache.sv ====
`timescale 1ns/1ps

module dcache import cache_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  addr_t     data_addr,
    input  word_t     data_wdata,
    input  strb_t     data_wstrb,
    input  logic      data_wr,
    input  logic      data_valid,
    output logic      data_ready,
    output word_t     data_rdata,
    output data_req_t l2_req,
    input  logic      l2_addr_ok,
    input  logic      l2_data_ok,
    input  line_t     l2_line
);

    logic [31:2+offset_width+d_index_width] tag_mem [1<<d_index_width];
    line_t                                  line_mem [1<<d_index_width];
    logic [(1<<d_index_width)-1:0]          valid_bits;
    dcache_state_t                          state;

    logic [d_index_width-1:0] index;
    logic [offset_width-1:0]  word_sel;
    logic                     hit;

    assign index    = data_addr[2+offset_width +: d_index_width];
    assign word_sel = data_addr[2 +: offset_width];
    assign hit      = valid_bits[index]
                   && tag_mem[index] == data_addr[31:2+offset_width+d_index_width];

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= d_lookup;
            valid_bits <= '0;
            data_ready <= 1'b0;
            l2_req.req <= 1'b0;
        end else begin
            data_ready <= 1'b0;
            case (state)
                d_lookup: begin
                    if (data_valid && !data_ready) begin
                        if (data_wr) begin
                            // write-through, no allocate on miss
                            if (hit) begin
                                for (int b = 0; b < 4; b++) begin
                                    if (data_wstrb[b])
                                        line_mem[index][word_sel*32 + b*8 +: 8] <= data_wdata[b*8 +: 8];
                                end
                            end
                            l2_req.addr  <= {data_addr[31:2], 2'b00};
                            l2_req.wdata <= data_wdata;
                            l2_req.wstrb <= data_wstrb;
                            l2_req.wr    <= 1'b1;
                            l2_req.req   <= 1'b1;
                            state        <= d_write_through;
                        end else if (hit) begin
                            data_ready <= 1'b1;
                            data_rdata <= line_mem[index][word_sel*32 +: 32];
                        end else begin
                            l2_req.addr <= {data_addr[31:2+offset_width], {(2+offset_width){1'b0}}};
                            l2_req.wr   <= 1'b0;
                            l2_req.req  <= 1'b1;
                            state       <= d_fill_addr;
                        end
                    end
                end
                d_fill_addr: if (l2_addr_ok) state <= d_fill_data;
                d_fill_data: begin
                    if (l2_data_ok) begin
                        line_mem[index]   <= l2_line;
                        tag_mem[index]    <= data_addr[31:2+offset_width+d_index_width];
                        valid_bits[index] <= 1'b1;
                        l2_req.req        <= 1'b0;
                        state             <= d_lookup;
                    end
                end
                d_write_through: begin
                    if (l2_data_ok) begin  // L2 has handed the write to memory
                        l2_req.req <= 1'b0;
                        data_ready <= 1'b1;
                        state      <= d_lookup;
                    end
                end
                default: state <= d_lookup;
            endcase
        end
    end

endmodule

// ==== l2cache/l2cache.sv ====
`timescale 1ns/1ps

module l2cache import cache_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  fetch_req_t i_req,
    output logic       i_addr_ok,
    output logic       i_data_ok,
    input  data_req_t  d_req,
    output logic       d_addr_ok,
    output logic       d_data_ok,
    output line_t      l1_line,
    output addr_t      mem_raddr,
    output logic       mem_req_r,
    input  logic       mem_addr_ok_r,
    input  line_t      mem_rdata,
    input  logic       mem_data_ok,
    output mem_wr_t    mem_wr,
    input  logic       mem_addr_ok_w
);

    logic [31:2+offset_width+l2_index_width] tag_mem [1<<l2_index_width];
    line_t                                   line_mem [1<<l2_index_width];
    logic [(1<<l2_index_width)-1:0]          valid_bits;
    l2_state_t                               state;

    data_req_t cur;      // latched request of the owner
    logic      owner_d;  // 1 when the dcache owns the L2

    logic [l2_index_width-1:0] index;
    logic [offset_width-1:0]   word_sel;
    logic                      hit;

    assign index    = cur.addr[2+offset_width +: l2_index_width];
    assign word_sel = cur.addr[2 +: offset_width];
    assign hit      = valid_bits[index]
                   && tag_mem[index] == cur.addr[31:2+offset_width+l2_index_width];

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= l2_idle;
            valid_bits <= '0;
            owner_d    <= 1'b0;
            i_addr_ok  <= 1'b0;
            i_data_ok  <= 1'b0;
            d_addr_ok  <= 1'b0;
            d_data_ok  <= 1'b0;
            mem_req_r  <= 1'b0;
            mem_wr.req <= 1'b0;
        end else begin
            i_addr_ok <= 1'b0;
            i_data_ok <= 1'b0;
            d_addr_ok <= 1'b0;
            d_data_ok <= 1'b0;
            case (state)
                l2_idle: begin
                    // wait out the dataOK cycle, the old req is still high
                    if (!i_data_ok && !d_data_ok) begin
                        if (d_req.req) begin  // dcache has priority
                            owner_d   <= 1'b1;
                            cur       <= d_req;
                            d_addr_ok <= 1'b1;
                            state     <= l2_lookup;
                        end else if (i_req.req) begin
                            owner_d   <= 1'b0;
                            cur.addr  <= i_req.addr;
                            cur.wr    <= 1'b0;
                            i_addr_ok <= 1'b1;
                            state     <= l2_lookup;
                        end
                    end
                end
                l2_lookup: begin
                    if (cur.wr) begin
                        if (hit) begin
                            for (int b = 0; b < 4; b++) begin
                                if (cur.wstrb[b])
                                    line_mem[index][word_sel*32 + b*8 +: 8] <= cur.wdata[b*8 +: 8];
                            end
                        end
                        mem_wr.addr  <= cur.addr;
                        mem_wr.data  <= line_t'(cur.wdata) << (word_sel*32);
                        mem_wr.wstrb <= cur.wstrb;
                        mem_wr.req   <= 1'b1;
                        state        <= l2_mem_write;
                    end else if (hit) begin
                        l1_line <= line_mem[index];
                        state   <= l2_respond;
                    end else begin
                        mem_raddr <= {cur.addr[31:2+offset_width], {(2+offset_width){1'b0}}};
                        mem_req_r <= 1'b1;
                        state     <= l2_mem_read_addr;
                    end
                end
                l2_mem_read_addr: begin
                    if (mem_addr_ok_r) begin
                        mem_req_r <= 1'b0;
                        state     <= l2_mem_read_data;
                    end
                end
                l2_mem_read_data: begin
                    if (mem_data_ok) begin
                        line_mem[index]   <= mem_rdata;
                        tag_mem[index]    <= cur.addr[31:2+offset_width+l2_index_width];
                        valid_bits[index] <= 1'b1;
                        l1_line           <= mem_rdata;
                        state             <= l2_respond;
                    end
                end
                l2_mem_write: begin
                    if (mem_addr_ok_w) begin  // write done once accepted
                        mem_wr.req <= 1'b0;
                        state      <= l2_respond;
                    end
                end
                l2_respond: begin
                    if (owner_d)
                        d_data_ok <= 1'b1;
                    else
                        i_data_ok <= 1'b1;
                    state <= l2_idle;
                end
                default: state <= l2_idle;
            endcase
        end
    end

endmodule

// ==== hw/l1_l2_cache.sv ====
`timescale 1ns/1ps

module l1_l2_cache import cache_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  addr_t   fetch_addr,
    input  logic    fetch_valid,
    output logic    fetch_ready,
    output word_t   fetch_inst,
    input  addr_t   data_addr,
    input  word_t   data_wdata,
    input  strb_t   data_wstrb,
    input  logic    data_wr,
    input  logic    data_valid,
    output logic    data_ready,
    output word_t   data_rdata,
    output addr_t   mem_raddr,
    output logic    mem_req_r,
    input  logic    mem_addr_ok_r,
    input  line_t   mem_rdata,
    input  logic    mem_data_ok,
    output mem_wr_t mem_wr,
    input  logic    mem_addr_ok_w
);

    fetch_req_t i_req;
    data_req_t  d_req;
    logic       i_addr_ok, i_data_ok;
    logic       d_addr_ok, d_data_ok;
    line_t      l1_line;  // fill line, shared by both L1s

    icache i_icache (
        .clk, .reset, .fetch_addr, .fetch_valid, .fetch_ready, .fetch_inst,
        .l2_req(i_req), .l2_addr_ok(i_addr_ok), .l2_data_ok(i_data_ok), .l2_line(l1_line)
    );

    dcache i_dcache (
        .clk, .reset, .data_addr, .data_wdata, .data_wstrb, .data_wr, .data_valid,
        .data_ready, .data_rdata,
        .l2_req(d_req), .l2_addr_ok(d_addr_ok), .l2_data_ok(d_data_ok), .l2_line(l1_line)
    );

    l2cache i_l2cache (
        .clk, .reset,
        .i_req, .i_addr_ok, .i_data_ok,
        .d_req, .d_addr_ok, .d_data_ok,
        .l1_line,
        .mem_raddr, .mem_req_r, .mem_addr_ok_r, .mem_rdata, .mem_data_ok,
        .mem_wr, .mem_addr_ok_w
    );

endmodule

// ==== bench/mem_model.sv ====
`timescale 1ns/1ps

module mem_model import cache_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  addr_t   raddr,
    input  logic    req_r,
    output logic    addr_ok_r,
    output line_t   rdata,
    output logic    data_ok,
    input  mem_wr_t wr,
    output logic    addr_ok_w
);

    word_t       words [addr_t];  // written words, by aligned address
    logic [31:0] lfsr;
    int          delay;
    logic        reading;  // address taken, line still owed
    addr_t       line_addr;
    addr_t       wa;
    word_t       wword;
    word_t       wslot;

    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
        end
        return r;
    endfunction

    function automatic word_t stored_word(input addr_t a);
        if (words.exists(a))
            return words[a];
        return a ^ 32'hc0de0000;
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            addr_ok_r <= 1'b0;
            data_ok   <= 1'b0;
            addr_ok_w <= 1'b0;
            reading   <= 1'b0;
            delay     <= 0;
            lfsr      = 32'hea9d0cba;
        end else begin
            addr_ok_r <= 1'b0;
            data_ok   <= 1'b0;
            addr_ok_w <= 1'b0;
            if (delay > 0) begin
                delay <= delay - 1;
            end else if (reading) begin
                for (int w = 0; w < line_words; w++)
                    rdata[w*32 +: 32] <= stored_word(line_addr + 32'(4 * w));
                data_ok <= 1'b1;
                reading <= 1'b0;
                delay   <= int'(next_bits(2));
            end else if (req_r && !addr_ok_r) begin
                addr_ok_r <= 1'b1;
                line_addr <= raddr;
                reading   <= 1'b1;
                delay     <= int'(next_bits(2));  // data delay
            end else if (wr.req && !addr_ok_w) begin
                wa    = {wr.addr[31:2], 2'b00};
                wword = stored_word(wa);
                wslot = wr.data[wr.addr[3:2]*32 +: 32];
                for (int b = 0; b < 4; b++) begin
                    if (wr.wstrb[b])
                        wword[b*8 +: 8] = wslot[b*8 +: 8];
                end
                words[wa] = wword;
                addr_ok_w <= 1'b1;
                delay     <= int'(next_bits(2));
            end
        end
    end

endmodule

// ==== bench/cache_properties.sv ====
`timescale 1ns/1ps

module cache_properties import cache_pkg::*; (
    input logic    clk,
    input logic    reset,
    input logic    mem_req_r,
    input logic    mem_addr_ok_r,
    input logic    fetch_valid,
    input logic    fetch_ready,
    input logic    data_valid,
    input logic    data_ready,
    input mem_wr_t mem_wr
);

    read_req_held: assert property (@(posedge clk) disable iff (reset)
        mem_req_r && !mem_addr_ok_r |=> mem_req_r)
        else $error("mem_req_r dropped before mem_addr_ok_r");

    fetch_ready_valid: assert property (@(posedge clk) disable iff (reset)
        fetch_ready |-> fetch_valid)
        else $error("fetch_ready without fetch_valid");

    data_ready_valid: assert property (@(posedge clk) disable iff (reset)
        data_ready |-> data_valid)
        else $error("data_ready without data_valid");

    // L2 serialises memory traffic
    one_mem_req: assert property (@(posedge clk) disable iff (reset)
        !(mem_req_r && mem_wr.req))
        else $error("memory read and write requested together");

endmodule

bind l1_l2_cache cache_properties i_props (.*);

// ==== bench/tb_l1_l2_cache.sv ====
`timescale 1ns/1ps

module tb_l1_l2_cache import cache_pkg::*; ();

    localparam addr_t code_base  = 32'h0000_1000;
    localparam addr_t data_base  = 32'h0001_0000;
    localparam int    wait_limit = 2000;

    logic    clk;
    logic    reset;
    addr_t   fetch_addr;
    logic    fetch_valid;
    logic    fetch_ready;
    word_t   fetch_inst;
    addr_t   data_addr;
    word_t   data_wdata;
    strb_t   data_wstrb;
    logic    data_wr;
    logic    data_valid;
    logic    data_ready;
    word_t   data_rdata;
    addr_t   mem_raddr;
    logic    mem_req_r;
    logic    mem_addr_ok_r;
    line_t   mem_rdata;
    logic    mem_data_ok;
    mem_wr_t mem_wr;
    logic    mem_addr_ok_w;

    logic [31:0] lfsr_state = 32'hea9d0cba;
    word_t       written [addr_t];  // bytes written so far per aligned word
    mem_wr_t     seen_writes [$];
    int          checks = 0;
    int          errors = 0;

    l1_l2_cache i_dut (.*);

    mem_model i_mem (
        .clk, .reset,
        .raddr(mem_raddr), .req_r(mem_req_r), .addr_ok_r(mem_addr_ok_r),
        .rdata(mem_rdata), .data_ok(mem_data_ok),
        .wr(mem_wr), .addr_ok_w(mem_addr_ok_w)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r          = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h80200003 : lfsr_state >> 1;
        end
        return r;
    endfunction

    // expected word from recorded writes over the memory rule
    function automatic word_t ref_word(input addr_t a);
        addr_t wa;
        wa = {a[31:2], 2'b00};
        if (written.exists(wa))
            return written[wa];
        return wa ^ 32'hc0de0000;
    endfunction

    task automatic record_write(input addr_t a, input word_t d, input strb_t s);
        addr_t wa;
        word_t w;
        wa = {a[31:2], 2'b00};
        w  = ref_word(wa);
        for (int b = 0; b < 4; b++) begin
            if (s[b])
                w[b*8 +: 8] = d[b*8 +: 8];
        end
        written[wa] = w;
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t: %s got %h expected %h", $time, name, actual, expected);
        end
    endtask

    // read results and memory writes sampled mid-cycle
    always @(negedge clk) begin
        if (!reset && fetch_ready)
            check_value("fetch_inst", fetch_inst, ref_word(fetch_addr));
        if (!reset && data_ready && !data_wr)
            check_value("data_rdata", data_rdata, ref_word(data_addr));
        if (!reset && mem_wr.req && mem_addr_ok_w)
            seen_writes.push_back(mem_wr);
    end

    task automatic fetch(input addr_t a, input bit expect_hit);
        int n;
        @(posedge clk);
        fetch_addr  <= a;
        fetch_valid <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!fetch_ready && n < wait_limit);
        if (!fetch_ready) begin
            errors++;
            $display("timeout: fetch of %h never got ready", a);
        end else if (expect_hit) begin
            check_value("fetch hit latency", n, 2);  // valid edge plus one cycle
        end
        @(posedge clk);
        fetch_valid <= 1'b0;
    endtask

    task automatic data_access(input addr_t a, input bit wr, input word_t d, input strb_t s,
                               input bit expect_hit);
        int      n;
        mem_wr_t seen;
        @(posedge clk);
        data_addr  <= a;
        data_wdata <= d;
        data_wstrb <= s;
        data_wr    <= wr;
        data_valid <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!data_ready && n < wait_limit);
        if (!data_ready) begin
            errors++;
            $display("timeout: data access to %h never got ready", a);
        end else begin
            if (expect_hit)
                check_value("data hit latency", n, 2);
            if (wr) begin
                record_write(a, d, s);
                if (seen_writes.size() == 0) begin
                    errors++;
                    $display("write to %h never showed up on the memory write port", a);
                end else begin
                    seen = seen_writes.pop_front();
                    check_value("mem_wr.addr", seen.addr, {a[31:2], 2'b00});
                    check_value("mem_wr word", seen.data[a[3:2]*32 +: 32], d);
                    check_value("mem_wr.wstrb", 32'(seen.wstrb), 32'(s));
                end
            end
        end
        @(posedge clk);
        data_valid <= 1'b0;
        data_wr    <= 1'b0;
    endtask

    initial begin
        addr_t ca;
        addr_t da;
        word_t d;
        strb_t s;
        logic [1:0] op;
        fetch_addr  = '0;
        fetch_valid = 1'b0;
        data_addr   = '0;
        data_wdata  = '0;
        data_wstrb  = '0;
        data_wr     = 1'b0;
        data_valid  = 1'b0;
        reset       = 1'b1;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        // cold miss then hits across the line
        fetch(code_base + 8, 0);
        fetch(code_base + 8, 1);
        fetch(code_base, 1);
        fetch(code_base + 4, 1);
        fetch(code_base + 12, 1);

        data_access(data_base + 4, 0, '0, '0, 0);
        data_access(data_base + 4, 0, '0, '0, 1);

        // strobed writes on a hit and a no-allocate miss
        data_access(data_base + 4, 1, 32'h11223344, 4'b0101, 0);
        data_access(data_base + 20, 1, 32'haabbccdd, 4'b1110, 0);
        data_access(data_base + 4, 0, '0, '0, 1);
        data_access(data_base + 20, 0, '0, '0, 0);
        data_access(data_base + 20, 1, 32'h55667788, 4'b0001, 0);
        data_access(data_base + 20, 0, '0, '0, 1);

        // 128 byte stride conflicts at both levels
        for (int k = 0; k < 4; k++)
            data_access(data_base + 8 + addr_t'(k * 128), 0, '0, '0, 0);
        for (int k = 3; k >= 0; k--)
            data_access(data_base + 8 + addr_t'(k * 128), 0, '0, '0, 0);
        fetch(code_base + 128, 0);
        fetch(code_base, 0);

        fork
            fetch(code_base + 32, 0);
            data_access(data_base + 64, 0, '0, '0, 0);
        join
        fork
            fetch(code_base + 36, 0);
            data_access(data_base + 68, 1, 32'hcafe0123, 4'b1001, 0);
        join

        for (int k = 0; k < 300; k++) begin
            op = 2'(next_bits(2));
            ca = code_base + (next_bits(6) << 2);
            da = data_base + (next_bits(7) << 2);
            d  = next_bits(32);
            s  = strb_t'(next_bits(4));
            case (op)
                2'd0: fetch(ca, 0);
                2'd1: data_access(da, 0, '0, '0, 0);
                2'd2: data_access(da, 1, d, s, 0);
                default: begin
                    fork
                        fetch(ca, 0);
                        data_access(da, s[0], d, s, 0);
                    join
                end
            endcase
        end

        repeat (4) @(posedge clk);
        if (seen_writes.size() != 0) begin
            errors++;
            $display("%0d unexpected writes left on the memory write port", seen_writes.size());
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== src.f ====
common/cache_pkg.sv
icache/icache.sv
dcache/dcache.sv
l2cache/l2cache.sv
hw/l1_l2_cache.sv
bench/mem_model.sv
bench/cache_properties.sv
bench/tb_l1_l2_cache.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_l1_l2_cache -f src.f -o sim_tb

./obj_dir/sim_tb > sim.log
cat sim.log

# result comes from the log
grep -q "PASS: all tests" sim.log
